/* sim.f */
verilog/exec_pkg.sv
verilog/lane_if.sv
verilog/wb_bus_if.sv
verilog/operand_forward.sv
verilog/lane_alu.sv
verilog/mul_unit.sv
verilog/writeback_stage.sv
verilog/exec_top.sv
tb/exec_asserts.sv
tb/tb_exec.sv

/* run.sh */
#!/bin/sh
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_exec \
    -f sim.f -o tb_exec_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_exec_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
    exit 0
fi
exit 1

/* tb/tb_exec.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_exec;

    typedef struct packed {
        exec_pkg::reg_addr_t r1;
        exec_pkg::reg_addr_t r2;
        exec_pkg::data_t     imm;
        logic                ui;
        exec_pkg::alu_op_t   op;
        logic                we;
        exec_pkg::reg_addr_t wa;
    } lane_t;

    typedef struct packed {
        logic                we_a;
        exec_pkg::reg_addr_t waddr_a;
        exec_pkg::data_t     wdata_a;
        logic                we_b;
        exec_pkg::reg_addr_t waddr_b;
        exec_pkg::data_t     wdata_b;
    } exp_t;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    lane_t la = '0;
    lane_t lb = '0;
    exec_pkg::wb_sel_t sel = exec_pkg::WB_ALU;
    exec_pkg::data_t rf [32] = '{default: '0};    // Committed state
    exec_pkg::data_t arch [32] = '{default: '0};  // Shadow updated at issue
    exp_t q [$];
    exp_t exp_cur = '0;
    logic exp_valid = 1'b0;
    logic [31:0] rng = 32'd14;
    int err_count = 0;
    int err_mark = 0;
    int bound_mark = 0;
    int test_count = 0;
    int lat;
    logic wb_we_a, wb_we_b;
    exec_pkg::reg_addr_t wb_waddr_a, wb_waddr_b;
    exec_pkg::data_t wb_wdata_a, wb_wdata_b;
    lane_t na, nb;

    exec_top exec_top_i (
        .clk(clk), .rst_n(rst_n),
        .a_raddr1(la.r1), .a_raddr2(la.r2), .a_rdata1(rf[la.r1]), .a_rdata2(rf[la.r2]),
        .a_imm(la.imm), .a_use_imm(la.ui), .a_alu_op(la.op), .a_we(la.we), .a_waddr(la.wa),
        .b_raddr1(lb.r1), .b_raddr2(lb.r2), .b_rdata1(rf[lb.r1]), .b_rdata2(rf[lb.r2]),
        .b_imm(lb.imm), .b_use_imm(lb.ui), .b_alu_op(lb.op), .b_we(lb.we), .b_waddr(lb.wa),
        .b_wb_sel(sel),
        .wb_we_a(wb_we_a), .wb_waddr_a(wb_waddr_a), .wb_wdata_a(wb_wdata_a),
        .wb_we_b(wb_we_b), .wb_waddr_b(wb_waddr_b), .wb_wdata_b(wb_wdata_b)
    );

    bind exec_top exec_asserts exec_asserts_i (
        .clk(clk), .rst_n(rst_n), .a_we(a_we), .b_we(b_we),
        .wb_we_a(wb_we_a), .wb_we_b(wb_we_b)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (wb_we_a && wb_waddr_a != 0) rf[wb_waddr_a] <= wb_wdata_a;
        if (wb_we_b && wb_waddr_b != 0) rf[wb_waddr_b] <= wb_wdata_b;  // Lane b lands last
    end

    wb_we_a_chk: assert property (@(posedge clk) disable iff (!rst_n || !exp_valid)
        wb_we_a == exp_cur.we_a)
        else begin
            err_count++;
            $display("ERR wb_we_a exp %h act %h", exp_cur.we_a, $sampled(wb_we_a));
        end

    wb_wr_a_chk: assert property (@(posedge clk) disable iff (!rst_n || !exp_valid)
        wb_we_a |-> (wb_waddr_a == exp_cur.waddr_a && wb_wdata_a == exp_cur.wdata_a))
        else begin
            err_count++;
            $display("ERR wb_waddr_a/wb_wdata_a exp %h/%h act %h/%h", exp_cur.waddr_a,
                     exp_cur.wdata_a, $sampled(wb_waddr_a), $sampled(wb_wdata_a));
        end

    wb_we_b_chk: assert property (@(posedge clk) disable iff (!rst_n || !exp_valid)
        wb_we_b == exp_cur.we_b)
        else begin
            err_count++;
            $display("ERR wb_we_b exp %h act %h", exp_cur.we_b, $sampled(wb_we_b));
        end

    wb_wr_b_chk: assert property (@(posedge clk) disable iff (!rst_n || !exp_valid)
        wb_we_b |-> (wb_waddr_b == exp_cur.waddr_b && wb_wdata_b == exp_cur.wdata_b))
        else begin
            err_count++;
            $display("ERR wb_waddr_b/wb_wdata_b exp %h/%h act %h/%h", exp_cur.waddr_b,
                     exp_cur.wdata_b, $sampled(wb_waddr_b), $sampled(wb_wdata_b));
        end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] draw();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic lane_t rand_lane();
        lane_t l;
        logic [31:0] r;
        r = draw();
        l.r1 = r[4:0];
        l.r2 = r[9:5];
        l.wa = r[14:10];
        l.op = exec_pkg::alu_op_t'(r[18:15] % 10);
        l.ui = r[19];
        l.we = r[22:20] != 3'd0;                  // Mostly writes
        l.imm = draw();
        return l;
    endfunction

    function automatic exec_pkg::data_t ref_alu(input exec_pkg::alu_op_t op,
                                                input exec_pkg::data_t a,
                                                input exec_pkg::data_t b);
        logic [63:0] ext;
        ext = {{32{a[31]}}, a} >> b[4:0];
        case (op)
            exec_pkg::ALU_ADD:  return a + b;
            exec_pkg::ALU_SUB:  return a + ~b + 32'd1;
            exec_pkg::ALU_AND:  return a & b;
            exec_pkg::ALU_OR:   return a | b;
            exec_pkg::ALU_XOR:  return a ^ b;
            exec_pkg::ALU_SLL:  return a << b[4:0];
            exec_pkg::ALU_SRL:  return a >> b[4:0];
            exec_pkg::ALU_SRA:  return ext[31:0];
            exec_pkg::ALU_SLT:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            exec_pkg::ALU_SLTU: return {31'd0, a < b};
            default:            return '0;
        endcase
    endfunction

    // One issue cycle, expectation leaves the queue two cycles later
    task automatic step(input lane_t pa, input lane_t pb, input exec_pkg::wb_sel_t ps);
        exp_t e;
        exec_pkg::prod_t p;
        @(negedge clk);
        la = pa;
        lb = pb;
        sel = ps;
        e.we_a = pa.we;
        e.waddr_a = pa.wa;
        e.wdata_a = ref_alu(pa.op, arch[pa.r1], pa.ui ? pa.imm : arch[pa.r2]);
        e.we_b = pb.we;
        e.waddr_b = pb.wa;
        p = {32'd0, arch[pb.r1]} * {32'd0, arch[pb.r2]};
        case (ps)
            exec_pkg::WB_MUL_LO: e.wdata_b = p[31:0];
            exec_pkg::WB_MUL_HI: e.wdata_b = p[63:32];
            default: e.wdata_b = ref_alu(pb.op, arch[pb.r1], pb.ui ? pb.imm : arch[pb.r2]);
        endcase
        if (pa.we && pa.wa != 0) arch[pa.wa] = e.wdata_a;
        if (pb.we && pb.wa != 0) arch[pb.wa] = e.wdata_b;  // Younger lane wins
        q.push_back(e);
        if (q.size() > 2) begin
            exp_cur = q.pop_front();
            exp_valid = 1'b1;
        end
    endtask

    task automatic finish_test(input string name);
        repeat (3) step('0, '0, exec_pkg::WB_ALU);  // Let the last pair reach WB
        err_count += exec_top_i.exec_asserts_i.fail_count - bound_mark;
        bound_mark = exec_top_i.exec_asserts_i.fail_count;
        test_count++;
        $display("test %s done, %0d errors", name, err_count - err_mark);
        err_mark = err_count;
    endtask

    initial begin
        for (int k = 1; k < 10; k++) begin      // Writes issued in reset are dropped
            @(negedge clk);
            la = '{0, 0, draw(), 1, exec_pkg::ALU_ADD, 1, k};
            lb = '{0, 0, draw(), 1, exec_pkg::ALU_ADD, 1, k + 10};
        end
        step('0, '0, exec_pkg::WB_ALU);
        rst_n = 1'b1;
        step('{0, 0, 32'h5a, 1, exec_pkg::ALU_ADD, 1, 3}, '0, exec_pkg::WB_ALU);
        lat = 0;
        do begin
            step('0, '0, exec_pkg::WB_ALU);
            lat++;
        end while (!wb_we_a && lat < 8);
        if (!wb_we_a) begin
            err_count++;
            $display("timeout: first issued write never reached the write-back outputs");
        end else begin
            first_lat: assert (lat == 2) else begin
                err_count++;
                $display("first write emerged after %0d cycles instead of 2", lat);
            end
        end
        finish_test("reset");

        for (int k = 1; k < 32; k += 2) begin     // Preload registers
            step('{0, 0, draw(), 1, exec_pkg::ALU_ADD, 1, k},
                 '{0, 0, draw(), 1, exec_pkg::ALU_ADD, 1, k + 1}, exec_pkg::WB_ALU);
        end
        for (int op = 0; op < 10; op++) begin
            for (int ui = 0; ui < 2; ui++) begin
                step('{op + 1, op + 3, draw(), ui, op, 1, 16 + op},
                     '{op + 2, op + 5, draw(), ui, op, 1, 26 + op % 6}, exec_pkg::WB_ALU);
            end
        end
        finish_test("independent");

        for (int d = 1; d < 3; d++) begin
            step('{1, 2, 0, 0, exec_pkg::ALU_ADD, 1, 5},
                 '{3, 4, draw(), 1, exec_pkg::ALU_XOR, 1, 6}, exec_pkg::WB_ALU);
            repeat (d - 1) step('0, '0, exec_pkg::WB_ALU);
            step('{5, 6, 0, 0, exec_pkg::ALU_SUB, 1, 20},
                 '{6, 5, 0, 0, exec_pkg::ALU_OR, 1, 21}, exec_pkg::WB_ALU);
            step('{1, 3, 0, 0, exec_pkg::ALU_ADD, 1, 7},
                 '{2, 4, 0, 0, exec_pkg::ALU_SUB, 1, 7}, exec_pkg::WB_ALU);
            repeat (d - 1) step('0, '0, exec_pkg::WB_ALU);
            step('{7, 1, 0, 0, exec_pkg::ALU_ADD, 1, 22}, '0, exec_pkg::WB_ALU);
            step('{1, 0, draw(), 1, exec_pkg::ALU_ADD, 1, 0},
                 '{2, 0, draw(), 1, exec_pkg::ALU_ADD, 1, 0}, exec_pkg::WB_ALU);
            repeat (d - 1) step('0, '0, exec_pkg::WB_ALU);
            step('{0, 0, 0, 0, exec_pkg::ALU_OR, 1, 23},
                 '{0, 1, 0, 0, exec_pkg::ALU_ADD, 1, 24}, exec_pkg::WB_ALU);
        end
        finish_test("forwarding");

        repeat (4) begin
            step('{0, 0, draw(), 1, exec_pkg::ALU_ADD, 1, 1},
                 '{0, 0, draw(), 1, exec_pkg::ALU_ADD, 1, 2}, exec_pkg::WB_ALU);
            step('0, '{1, 2, 0, 0, exec_pkg::ALU_ADD, 1, 8}, exec_pkg::WB_MUL_LO);
            step('{8, 0, 0, 0, exec_pkg::ALU_ADD, 1, 9},
                 '{1, 2, 0, 0, exec_pkg::ALU_ADD, 1, 10}, exec_pkg::WB_MUL_HI);
            step('{10, 8, 0, 0, exec_pkg::ALU_XOR, 1, 11}, '0, exec_pkg::WB_ALU);
        end
        finish_test("multiply");

        repeat (300) begin
            na = rand_lane();
            nb = rand_lane();
            if (na.we && nb.r1 == na.wa) nb.r1 = '0;  // Keep the pair free of a-to-b reads
            if (na.we && nb.r2 == na.wa) nb.r2 = '0;
            step(na, nb, exec_pkg::wb_sel_t'(draw() % 3));
        end
        finish_test("random");

        $display("%0d tests, %0d errors", test_count, err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/exec_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_asserts (
    input logic clk,
    input logic rst_n,
    input logic a_we,
    input logic b_we,
    input logic wb_we_a,
    input logic wb_we_b
);

    int fail_count = 0;                           // Failed assertions so far

    // Reset clears both stages, so WB stays quiet for two more edges
    reset_quiet_next: assert property (@(posedge clk)
        !rst_n |=> (!wb_we_a && !wb_we_b))
        else begin
            fail_count++;
            $error("write enable active in the cycle after a reset edge");
        end

    reset_quiet_later: assert property (@(posedge clk)
        !rst_n |=> ##1 (!wb_we_a && !wb_we_b))
        else begin
            fail_count++;
            $error("write enable active two cycles after a reset edge");
        end

    // Fixed two-cycle issue-to-WB latency
    lat_a: assert property (@(posedge clk) disable iff (!rst_n)
        wb_we_a |-> $past(a_we, 2))
        else begin
            fail_count++;
            $error("lane a write enable without an issued write two cycles earlier");
        end

    lat_b: assert property (@(posedge clk) disable iff (!rst_n)
        wb_we_b |-> $past(b_we, 2))
        else begin
            fail_count++;
            $error("lane b write enable without an issued write two cycles earlier");
        end

endmodule

`default_nettype wire

/* verilog/exec_top.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_top (
    input  logic                clk,
    input  logic                rst_n,

    input  exec_pkg::reg_addr_t a_raddr1,
    input  exec_pkg::reg_addr_t a_raddr2,
    input  exec_pkg::data_t     a_rdata1,
    input  exec_pkg::data_t     a_rdata2,
    input  exec_pkg::data_t     a_imm,
    input  logic                a_use_imm,
    input  exec_pkg::alu_op_t   a_alu_op,
    input  logic                a_we,
    input  exec_pkg::reg_addr_t a_waddr,

    input  exec_pkg::reg_addr_t b_raddr1,
    input  exec_pkg::reg_addr_t b_raddr2,
    input  exec_pkg::data_t     b_rdata1,
    input  exec_pkg::data_t     b_rdata2,
    input  exec_pkg::data_t     b_imm,
    input  logic                b_use_imm,
    input  exec_pkg::alu_op_t   b_alu_op,
    input  logic                b_we,
    input  exec_pkg::reg_addr_t b_waddr,
    input  exec_pkg::wb_sel_t   b_wb_sel,     // ALU or product word

    output logic                wb_we_a,
    output exec_pkg::reg_addr_t wb_waddr_a,
    output exec_pkg::data_t     wb_wdata_a,
    output logic                wb_we_b,
    output exec_pkg::reg_addr_t wb_waddr_b,
    output exec_pkg::data_t     wb_wdata_b
);

    lane_if   lane_a ();
    lane_if   lane_b ();
    wb_bus_if mem_bus ();
    wb_bus_if wb_bus ();

    exec_pkg::data_t opnd_a1;
    exec_pkg::data_t opnd_a2;
    exec_pkg::data_t opnd_b1;
    exec_pkg::data_t opnd_b2;
    exec_pkg::data_t alu_result_a;
    exec_pkg::data_t alu_result_b;
    exec_pkg::prod_t mem_product;

    assign lane_a.raddr1  = a_raddr1;
    assign lane_a.raddr2  = a_raddr2;
    assign lane_a.rdata1  = a_rdata1;
    assign lane_a.rdata2  = a_rdata2;
    assign lane_a.imm     = a_imm;
    assign lane_a.use_imm = a_use_imm;
    assign lane_a.alu_op  = a_alu_op;
    assign lane_a.we      = a_we;
    assign lane_a.waddr   = a_waddr;

    assign lane_b.raddr1  = b_raddr1;
    assign lane_b.raddr2  = b_raddr2;
    assign lane_b.rdata1  = b_rdata1;
    assign lane_b.rdata2  = b_rdata2;
    assign lane_b.imm     = b_imm;
    assign lane_b.use_imm = b_use_imm;
    assign lane_b.alu_op  = b_alu_op;
    assign lane_b.we      = b_we;
    assign lane_b.waddr   = b_waddr;

    operand_forward operand_forward_i (
        .lane_a  (lane_a),
        .lane_b  (lane_b),
        .mem_bus (mem_bus),
        .wb_bus  (wb_bus),
        .opnd_a1 (opnd_a1),
        .opnd_a2 (opnd_a2),
        .opnd_b1 (opnd_b1),
        .opnd_b2 (opnd_b2)
    );

    lane_alu lane_alu_a_i (
        .lane   (lane_a),
        .opnd1  (opnd_a1),
        .opnd2  (opnd_a2),
        .result (alu_result_a)
    );

    lane_alu lane_alu_b_i (
        .lane   (lane_b),
        .opnd1  (opnd_b1),
        .opnd2  (opnd_b2),
        .result (alu_result_b)
    );

    mul_unit mul_unit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .x           (opnd_b1),               // Register operands, never the immediate
        .y           (opnd_b2),
        .mem_product (mem_product)
    );

    writeback_stage writeback_stage_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .lane_a       (lane_a),
        .lane_b       (lane_b),
        .alu_result_a (alu_result_a),
        .alu_result_b (alu_result_b),
        .wb_sel_b     (b_wb_sel),
        .mem_product  (mem_product),
        .mem_bus      (mem_bus),
        .wb_bus       (wb_bus)
    );

    assign wb_we_a    = wb_bus.we_a;
    assign wb_waddr_a = wb_bus.waddr_a;
    assign wb_wdata_a = wb_bus.wdata_a;
    assign wb_we_b    = wb_bus.we_b;
    assign wb_waddr_b = wb_bus.waddr_b;
    assign wb_wdata_b = wb_bus.wdata_b;

endmodule

`default_nettype wire

/* verilog/writeback_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module writeback_stage (
    input  logic              clk,
    input  logic              rst_n,
    lane_if.wb                lane_a,
    lane_if.wb                lane_b,
    input  exec_pkg::data_t   alu_result_a,
    input  exec_pkg::data_t   alu_result_b,
    input  exec_pkg::wb_sel_t wb_sel_b,
    input  exec_pkg::prod_t   mem_product,
    wb_bus_if.source          mem_bus,
    wb_bus_if.source          wb_bus
);

    localparam int XLEN = exec_pkg::XLEN;

    logic                mem_we_a;
    logic                mem_we_b;
    exec_pkg::reg_addr_t mem_waddr_a;
    exec_pkg::reg_addr_t mem_waddr_b;
    exec_pkg::data_t     mem_alu_a;
    exec_pkg::data_t     mem_alu_b;
    exec_pkg::wb_sel_t   mem_sel_b;
    exec_pkg::data_t     mem_wdata_b;

    logic                wb_we_a;
    logic                wb_we_b;
    exec_pkg::reg_addr_t wb_waddr_a;
    exec_pkg::reg_addr_t wb_waddr_b;
    exec_pkg::data_t     wb_wdata_a;
    exec_pkg::data_t     wb_wdata_b;

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_we_a <= 1'b0;
            mem_we_b <= 1'b0;
        end else begin
            mem_we_a <= lane_a.we;
            mem_we_b <= lane_b.we;
        end
    end

    always_ff @(posedge clk) begin
        mem_waddr_a <= lane_a.waddr;
        mem_waddr_b <= lane_b.waddr;
        mem_alu_a   <= alu_result_a;
        mem_alu_b   <= alu_result_b;
        mem_sel_b   <= wb_sel_b;                  // Product lands in MEM alongside it
    end

    // Lane b result select, product is valid this cycle
    always_comb begin
        case (mem_sel_b)
            exec_pkg::WB_ALU: begin
                mem_wdata_b = mem_alu_b;
            end
            exec_pkg::WB_MUL_LO: begin
                mem_wdata_b = mem_product[XLEN-1:0];
            end
            exec_pkg::WB_MUL_HI: begin
                mem_wdata_b = mem_product[2*XLEN-1:XLEN];
            end
            default: begin
                mem_wdata_b = '0;                 // Reserved select
            end
        endcase
    end

    assign mem_bus.we_a    = mem_we_a;
    assign mem_bus.waddr_a = mem_waddr_a;
    assign mem_bus.wdata_a = mem_alu_a;
    assign mem_bus.we_b    = mem_we_b;
    assign mem_bus.waddr_b = mem_waddr_b;
    assign mem_bus.wdata_b = mem_wdata_b;         // Post-select value is forwardable

    // MEM/WB register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_we_a <= 1'b0;
            wb_we_b <= 1'b0;
        end else begin
            wb_we_a <= mem_we_a;
            wb_we_b <= mem_we_b;
        end
    end

    always_ff @(posedge clk) begin
        wb_waddr_a <= mem_waddr_a;
        wb_waddr_b <= mem_waddr_b;
        wb_wdata_a <= mem_alu_a;
        wb_wdata_b <= mem_wdata_b;
    end

    assign wb_bus.we_a    = wb_we_a;
    assign wb_bus.waddr_a = wb_waddr_a;
    assign wb_bus.wdata_a = wb_wdata_a;
    assign wb_bus.we_b    = wb_we_b;
    assign wb_bus.waddr_b = wb_waddr_b;
    assign wb_bus.wdata_b = wb_wdata_b;

endmodule

`default_nettype wire

/* verilog/mul_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module mul_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  exec_pkg::data_t  x,
    input  exec_pkg::data_t  y,
    output exec_pkg::prod_t  mem_product
);

    localparam int HALF = exec_pkg::XLEN / 2;
    localparam int PPW  = exec_pkg::XLEN + HALF;  // Partial product width

    logic [PPW-1:0] ex_pp_lo;
    logic [PPW-1:0] ex_pp_hi;
    logic [PPW-1:0] mem_pp_lo;
    logic [PPW-1:0] mem_pp_hi;

    // EX half: two narrow multiplies on the halves of y
    assign ex_pp_lo = PPW'(x) * PPW'(y[HALF-1:0]);
    assign ex_pp_hi = PPW'(x) * PPW'(y[exec_pkg::XLEN-1:HALF]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_pp_lo <= '0;
            mem_pp_hi <= '0;
        end else begin
            mem_pp_lo <= ex_pp_lo;                // EX/MEM boundary
            mem_pp_hi <= ex_pp_hi;
        end
    end

    // MEM half: align the upper partial product and sum
    assign mem_product = exec_pkg::prod_t'(mem_pp_lo)
                       + (exec_pkg::prod_t'(mem_pp_hi) << HALF);

endmodule

`default_nettype wire

/* verilog/lane_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module lane_alu (
    lane_if.alu              lane,
    input  exec_pkg::data_t  opnd1,
    input  exec_pkg::data_t  opnd2,
    output exec_pkg::data_t  result
);

    exec_pkg::data_t op2;
    logic [4:0]      shamt;

    assign op2   = lane.use_imm ? lane.imm : opnd2;
    assign shamt = op2[4:0];                      // Low 5 bits only

    always_comb begin
        case (lane.alu_op)
            exec_pkg::ALU_ADD: begin
                result = opnd1 + op2;
            end
            exec_pkg::ALU_SUB: begin
                result = opnd1 - op2;
            end
            exec_pkg::ALU_AND: begin
                result = opnd1 & op2;
            end
            exec_pkg::ALU_OR: begin
                result = opnd1 | op2;
            end
            exec_pkg::ALU_XOR: begin
                result = opnd1 ^ op2;
            end
            exec_pkg::ALU_SLL: begin
                result = opnd1 << shamt;
            end
            exec_pkg::ALU_SRL: begin
                result = opnd1 >> shamt;
            end
            exec_pkg::ALU_SRA: begin
                result = exec_pkg::data_t'($signed(opnd1) >>> shamt);
            end
            exec_pkg::ALU_SLT: begin
                result = {31'd0, $signed(opnd1) < $signed(op2)};
            end
            exec_pkg::ALU_SLTU: begin
                result = {31'd0, opnd1 < op2};
            end
            default: begin
                result = '0;                      // Unused opcodes
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/operand_forward.sv */
`timescale 1ns/1ns
`default_nettype none

module operand_forward (
    lane_if.fwd          lane_a,
    lane_if.fwd          lane_b,
    wb_bus_if.sink       mem_bus,
    wb_bus_if.sink       wb_bus,
    output exec_pkg::data_t opnd_a1,
    output exec_pkg::data_t opnd_a2,
    output exec_pkg::data_t opnd_b1,
    output exec_pkg::data_t opnd_b2
);

    // Newest producer wins: MEM before WB, lane b before lane a
    function automatic exec_pkg::data_t fwd_value(
        input exec_pkg::reg_addr_t raddr,
        input exec_pkg::data_t     rdata
    );
        if (raddr == '0) begin
            return rdata;                         // r0 is never forwarded
        end else if (mem_bus.we_b && mem_bus.waddr_b == raddr) begin
            return mem_bus.wdata_b;
        end else if (mem_bus.we_a && mem_bus.waddr_a == raddr) begin
            return mem_bus.wdata_a;
        end else if (wb_bus.we_b && wb_bus.waddr_b == raddr) begin
            return wb_bus.wdata_b;
        end else if (wb_bus.we_a && wb_bus.waddr_a == raddr) begin
            return wb_bus.wdata_a;
        end else begin
            return rdata;                         // Committed value
        end
    endfunction

    always_comb begin
        opnd_a1 = fwd_value(lane_a.raddr1, lane_a.rdata1);
        opnd_a2 = fwd_value(lane_a.raddr2, lane_a.rdata2);
        opnd_b1 = fwd_value(lane_b.raddr1, lane_b.rdata1);  // No a-to-b bypass in a pair
        opnd_b2 = fwd_value(lane_b.raddr2, lane_b.rdata2);
    end

endmodule

`default_nettype wire

/* verilog/wb_bus_if.sv */
`timescale 1ns/1ns
`default_nettype none

// Register writes of both lanes in one stage
interface wb_bus_if;

    logic                we_a;
    exec_pkg::reg_addr_t waddr_a;
    exec_pkg::data_t     wdata_a;
    logic                we_b;                    // Lane b is younger
    exec_pkg::reg_addr_t waddr_b;
    exec_pkg::data_t     wdata_b;

    modport source (
        output we_a, waddr_a, wdata_a,
        output we_b, waddr_b, wdata_b
    );

    modport sink (
        input we_a, waddr_a, wdata_a,
        input we_b, waddr_b, wdata_b
    );

endinterface

`default_nettype wire

/* verilog/lane_if.sv */
`timescale 1ns/1ns
`default_nettype none

// One issue lane as it enters EX
interface lane_if;

    exec_pkg::reg_addr_t raddr1;
    exec_pkg::reg_addr_t raddr2;
    exec_pkg::data_t     rdata1;                  // Raw register-file data
    exec_pkg::data_t     rdata2;
    exec_pkg::data_t     imm;
    logic                use_imm;                 // Immediate replaces operand 2
    exec_pkg::alu_op_t   alu_op;
    logic                we;
    exec_pkg::reg_addr_t waddr;

    modport fwd (
        input raddr1,
        input raddr2,
        input rdata1,
        input rdata2
    );

    modport alu (
        input imm,
        input use_imm,
        input alu_op
    );

    modport wb (
        input we,
        input waddr
    );

endinterface

`default_nettype wire

/* verilog/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    localparam int XLEN = 32;                     // Integer ISA word width

    typedef logic [XLEN-1:0]   data_t;            // Register value or immediate
    typedef logic [4:0]        reg_addr_t;        // Architectural register number
    typedef logic [2*XLEN-1:0] prod_t;            // Full unsigned product
    typedef logic [3:0]        alu_op_t;
    typedef logic [1:0]        wb_sel_t;          // Lane b writeback source

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_SLL  = 4'd5;           // Shift by operand 2 low 5 bits
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_SLT  = 4'd8;           // Signed compare
    localparam alu_op_t ALU_SLTU = 4'd9;

    localparam wb_sel_t WB_ALU    = 2'd0;
    localparam wb_sel_t WB_MUL_LO = 2'd1;         // Low word of product
    localparam wb_sel_t WB_MUL_HI = 2'd2;         // High word of product

endpackage

`default_nettype wire
